/* hdl/pmpPkg.sv */
`default_nettype none

package pmpPkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and CSR numbers
  ////////////////////////////////////////////////////////////////////////////

  // only the RV32 CSR layout is supported
  localparam int xlen = 32;

  // widest physical address any instance may use (Sv32 gives 34 bits)
  localparam int paMax = 34;

  typedef logic [11:0] csrAdrT;

  // pmpcfg0..3 and pmpaddr0..15 sit in two aligned blocks
  localparam csrAdrT csrPmpCfgBase = 12'h3A0;
  localparam csrAdrT csrPmpAdrBase = 12'h3B0;

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////

  // address-matching mode, in the order of the A field
  typedef enum logic [1:0] {
    adrOff   = 2'b00,
    adrTor   = 2'b01,
    adrNa4   = 2'b10,
    adrNapot = 2'b11
  } adrModeT;

  typedef enum logic [1:0] {
    accRead  = 2'b00,
    accWrite = 2'b01,
    accExec  = 2'b10
  } accTypeT;

  // standard privilege encoding, 2'b10 is unused
  typedef enum logic [1:0] {
    privUser    = 2'b00,
    privSuper   = 2'b01,
    privMachine = 2'b11
  } privT;

  ////////////////////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////////////////////

  // one cfg byte, high bit first
  typedef struct packed {
    logic    l;
    logic [1:0] rsvd;
    adrModeT a;
    logic    x;
    logic    w;
    logic    r;
  } pmpCfgT;

  // the address field is sized for the widest case, narrower units use the low bits
  typedef struct packed {
    logic [paMax-1:0] adr;
    accTypeT          accType;
    privT             priv;
  } accessReqT;

  typedef struct packed {
    logic       fault;
    logic       matched;
    logic [3:0] matchIdx;
  } accessRespT;

endpackage

`default_nettype wire

/* hdl/pmpAdrDec.sv */
`timescale 1ns/1ns
`default_nettype none

module pmpAdrDec import pmpPkg::*; #(
  parameter int paBits = 34
) (
  input  logic [paBits-1:0] adr,
  input  adrModeT           adrMode,
  input  logic [xlen-1:0]   curPmpAdr,
  input  logic              atLeastPrev,
  output logic              atLeastCur,
  output logic              match
);

  // pmpaddr holds bits paBits-1..2 of the byte address
  logic [paBits-1:0] curAdrFull;
  logic              belowCur;
  logic              torMatch;
  logic              naMatch;
  logic [paBits-1:0] ignoreMask;

  ////////////////////////////////////////////////////////////////////////////
  // top of range
  ////////////////////////////////////////////////////////////////////////////

  // the two implicit low zero bits turn the word bound into a byte bound
  assign curAdrFull = {curPmpAdr[paBits-3:0], 2'b00};

  // unsigned compare, both sides are plain logic vectors
  assign belowCur = adr < curAdrFull;

  // the next entry needs this bound even if this entry is off or naturally aligned
  assign atLeastCur = ~belowCur;

  // lower bound comes from the entry below, entry 0 gets a constant true
  assign torMatch = atLeastPrev & belowCur;

  ////////////////////////////////////////////////////////////////////////////
  // naturally aligned regions
  ////////////////////////////////////////////////////////////////////////////

  // a one in the mask marks an address bit that is ignored in the compare
  always_comb begin
    ignoreMask[1:0] = 2'b11;
    // NA4 stops here, so the mask stays at the lowest two bits
    ignoreMask[2] = (adrMode == adrNapot);
    // each trailing one of pmpaddr doubles the NAPOT region
    for (int i = 3; i < paBits; i++) begin
      ignoreMask[i] = ignoreMask[i-1] & curPmpAdr[i-3];
    end
  end

  // every bit not masked must equal the base
  assign naMatch = &(~(adr ^ curAdrFull) | ignoreMask);

  always_comb begin
    case (adrMode)
      adrTor:   match = torMatch;
      adrNa4:   match = naMatch;
      adrNapot: match = naMatch;
      default:  match = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/pmpCsrFile.sv */
`timescale 1ns/1ns
`default_nettype none

module pmpCsrFile import pmpPkg::*; #(
  parameter int nEntries = 16
) (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic                           csrWrite,
  input  csrAdrT                         csrAdr,
  input  logic [xlen-1:0]                csrWData,
  output logic [xlen-1:0]                csrRData,
  output logic                           csrHit,
  output pmpCfgT [nEntries-1:0]          cfgVec,
  output logic   [nEntries-1:0][xlen-1:0] adrVec
);

  logic                  cfgWordHit;
  logic [1:0]            cfgWordIdx;
  logic                  adrRegHit;
  logic [3:0]            adrRegIdx;
  pmpCfgT [3:0]          wrCfgBytes;
  logic [nEntries-1:0]   adrLocked;
  logic [nEntries-1:0]   cfgWe;
  logic [nEntries-1:0]   adrWe;

  ////////////////////////////////////////////////////////////////////////////
  // CSR number decode
  ////////////////////////////////////////////////////////////////////////////

  // pmpcfg0..3 share the upper ten bits, pmpaddr0..15 share the upper eight
  assign cfgWordHit = (csrAdr[11:2] == csrPmpCfgBase[11:2]);
  assign cfgWordIdx = csrAdr[1:0];
  assign adrRegHit  = (csrAdr[11:4] == csrPmpAdrBase[11:4]);
  assign adrRegIdx  = csrAdr[3:0];

  // the whole architectural range hits, even entries this unit does not build
  assign csrHit = cfgWordHit | adrRegHit;

  // split the write word into four cfg bytes with the reserved bits cleared
  always_comb begin
    for (int j = 0; j < 4; j++) begin
      wrCfgBytes[j]      = pmpCfgT'(csrWData[8*j +: 8]);
      wrCfgBytes[j].rsvd = 2'b00;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // lock rules
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // an entry's own lock freezes its address
    for (int e = 0; e < nEntries; e++) begin
      adrLocked[e] = cfgVec[e].l;
    end
    // a locked TOR entry also freezes the bound below it
    for (int e = 0; e < nEntries - 1; e++) begin
      if (cfgVec[e+1].l && (cfgVec[e+1].a == adrTor)) begin
        adrLocked[e] = 1'b1;
      end
    end
  end

  // each cfg byte is gated by its own lock, so the rest of the word still lands
  always_comb begin
    for (int e = 0; e < nEntries; e++) begin
      cfgWe[e] = csrWrite && cfgWordHit && (int'(cfgWordIdx) == e / 4) && !cfgVec[e].l;
      adrWe[e] = csrWrite && adrRegHit && (int'(adrRegIdx) == e) && !adrLocked[e];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  // only reset can clear a lock bit once it is set
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cfgVec <= '0;
      adrVec <= '0;
    end else begin
      for (int e = 0; e < nEntries; e++) begin
        if (cfgWe[e]) begin
          cfgVec[e] <= wrCfgBytes[e % 4];
        end
        if (adrWe[e]) begin
          adrVec[e] <= csrWData;
        end
      end
    end
  end

  // readback is combinational, entries not built read as zero
  always_comb begin
    csrRData = '0;
    for (int e = 0; e < nEntries; e++) begin
      if (cfgWordHit && (int'(cfgWordIdx) == e / 4)) begin
        csrRData[8*(e % 4) +: 8] = cfgVec[e];
      end
      if (adrRegHit && (int'(adrRegIdx) == e)) begin
        csrRData = adrVec[e];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/pmpPrioritySel.sv */
`timescale 1ns/1ns
`default_nettype none

module pmpPrioritySel import pmpPkg::*; #(
  parameter int nEntries = 16
) (
  input  logic   [nEntries-1:0] matchVec,
  input  pmpCfgT [nEntries-1:0] cfgVec,
  input  accTypeT               accType,
  input  privT                  priv,
  output accessRespT            respNext
);

  logic       anyMatch;
  logic [3:0] selIdx;
  pmpCfgT     selCfg;
  logic       permOk;

  assign anyMatch = |matchVec;

  // scanning from the top down leaves the lowest matching entry selected
  always_comb begin
    selIdx = '0;
    selCfg = '0;
    for (int e = nEntries - 1; e >= 0; e--) begin
      if (matchVec[e]) begin
        selIdx = 4'(e);
        selCfg = cfgVec[e];
      end
    end
  end

  // the permission bit that belongs to this access type
  always_comb begin
    case (accType)
      accRead:  permOk = selCfg.r;
      accWrite: permOk = selCfg.w;
      accExec:  permOk = selCfg.x;
      default:  permOk = 1'b0;
    endcase
  end

  always_comb begin
    respNext.matched  = anyMatch;
    respNext.matchIdx = selIdx;
    if (anyMatch) begin
      // machine mode ignores the permissions of an unlocked entry
      if ((priv == privMachine) && !selCfg.l) begin
        respNext.fault = 1'b0;
      end else begin
        respNext.fault = ~permOk;
      end
    end else begin
      // no entry matched, only machine mode gets through
      respNext.fault = (priv != privMachine);
    end
  end

endmodule

`default_nettype wire

/* hdl/pmpChecker.sv */
`timescale 1ns/1ns
`default_nettype none

module pmpChecker import pmpPkg::*; #(
  parameter int nEntries = 16,
  parameter int paBits   = 34
) (
  input  logic                            clk,
  input  logic                            arstN,
  input  logic                            reqValid,
  input  accessReqT                       req,
  input  pmpCfgT [nEntries-1:0]           cfgVec,
  input  logic   [nEntries-1:0][xlen-1:0] adrVec,
  output logic                            respValid,
  output accessRespT                      resp
);

  // atLeast[i] says the address is at or above the bound of entry i-1
  logic [nEntries:0]   atLeast;
  logic [nEntries-1:0] matchVec;
  accessRespT          respNext;

  ////////////////////////////////////////////////////////////////////////////
  // one address decoder per entry
  ////////////////////////////////////////////////////////////////////////////

  // TOR entry 0 starts at address zero, so its lower bound always holds
  assign atLeast[0] = 1'b1;

  for (genvar i = 0; i < nEntries; i++) begin : gDec
    pmpAdrDec #(
      .paBits(paBits)
    ) adrDec (
      .adr        (req.adr[paBits-1:0]),
      .adrMode    (cfgVec[i].a),
      .curPmpAdr  (adrVec[i]),
      .atLeastPrev(atLeast[i]),
      .atLeastCur (atLeast[i+1]),
      .match      (matchVec[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // priority and permission decision
  ////////////////////////////////////////////////////////////////////////////

  pmpPrioritySel #(
    .nEntries(nEntries)
  ) prioritySel (
    .matchVec(matchVec),
    .cfgVec  (cfgVec),
    .accType (req.accType),
    .priv    (req.priv),
    .respNext(respNext)
  );

  ////////////////////////////////////////////////////////////////////////////
  // response register
  ////////////////////////////////////////////////////////////////////////////

  // the decision uses the CSR state from before this edge, one request per cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      respValid <= 1'b0;
    end else begin
      respValid <= reqValid;
    end
  end

  // payload only moves when a request is sampled
  always_ff @(posedge clk) begin
    if (reqValid) begin
      resp <= respNext;
    end
  end

endmodule

`default_nettype wire

/* hdl/pmpUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module pmpUnit import pmpPkg::*; #(
  parameter int nEntries = 16,
  parameter int paBits   = 34
) (
  input  logic            clk,
  input  logic            arstN,
  input  logic            csrWrite,
  input  csrAdrT          csrAdr,
  input  logic [xlen-1:0] csrWData,
  output logic [xlen-1:0] csrRData,
  output logic            csrHit,
  input  logic            reqValid,
  input  accessReqT       req,
  output logic            respValid,
  output accessRespT      resp
);

  // register outputs of the CSR file feed the checker directly
  pmpCfgT [nEntries-1:0]           cfgVec;
  logic   [nEntries-1:0][xlen-1:0] adrVec;

  pmpCsrFile #(
    .nEntries(nEntries)
  ) csrFile (
    .clk     (clk),
    .arstN   (arstN),
    .csrWrite(csrWrite),
    .csrAdr  (csrAdr),
    .csrWData(csrWData),
    .csrRData(csrRData),
    .csrHit  (csrHit),
    .cfgVec  (cfgVec),
    .adrVec  (adrVec)
  );

  pmpChecker #(
    .nEntries(nEntries),
    .paBits  (paBits)
  ) accessChecker (
    .clk      (clk),
    .arstN    (arstN),
    .reqValid (reqValid),
    .req      (req),
    .cfgVec   (cfgVec),
    .adrVec   (adrVec),
    .respValid(respValid),
    .resp     (resp)
  );

endmodule

`default_nettype wire

/* testbench/pmpUnitTb.sv */
`timescale 1ns/1ns
`default_nettype none

module pmpUnitTb import pmpPkg::*; ();

  typedef enum logic [1:0] {stepWrite, stepRead, stepAccess, stepMiss} stepKindT;

  // one table row, for a read the data field holds the expected value
  typedef struct packed {
    stepKindT        kind;
    csrAdrT          adr;
    logic [xlen-1:0] data;
    accessReqT       req;
    accessRespT      expResp;
  } stepT;

  // 64 KiB NAPOT region of entry 4, also the target of the random sweep
  localparam logic [paMax-1:0] napotBase = 34'h2_ABCD_0000;

  logic            clk;
  logic            arstN;
  logic            csrWrite;
  csrAdrT          csrAdr;
  logic [xlen-1:0] csrWData;
  logic [xlen-1:0] csrRData;
  logic            csrHit;
  logic            reqValid;
  accessReqT       req;
  logic            respValid;
  accessRespT      resp;
  stepT            steps[$];
  integer          seed;

  pmpUnit uut (
    .clk      (clk),
    .arstN    (arstN),
    .csrWrite (csrWrite),
    .csrAdr   (csrAdr),
    .csrWData (csrWData),
    .csrRData (csrRData),
    .csrHit   (csrHit),
    .reqValid (reqValid),
    .req      (req),
    .respValid(respValid),
    .resp     (resp)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkCsr(input csrAdrT adr, input logic [xlen-1:0] expected,
                          input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      abortRun($sformatf("MISMATCH at %0t ns: CSR %h read %h, expected %h",
                         $time, adr, actual, expected));
    end
  endtask

  task automatic checkResp(input accessReqT r, input accessRespT expected,
                           input accessRespT actual);
    if (actual !== expected) begin
      abortRun($sformatf("MISMATCH at %0t ns: access %h type %0d priv %0d gave %b, expected %b",
                         $time, r.adr, r.accType, r.priv, actual, expected));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus actions, each starts and ends on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic runWrite(input csrAdrT adr, input logic [xlen-1:0] data);
    csrWrite = 1'b1;
    csrAdr   = adr;
    csrWData = data;
    @(negedge clk);
    csrWrite = 1'b0;
    // no request was sampled at the last edge, so the response pulse is over
    if (respValid) begin
      abortRun("respValid stayed high for more than one cycle");
    end
  endtask

  // readback is combinational, so sample it a little after the address settles
  task automatic runRead(input csrAdrT adr, input logic [xlen-1:0] expected);
    csrAdr = adr;
    #20;
    if (!csrHit) begin
      abortRun($sformatf("csrHit stayed low for PMP CSR %h", adr));
    end
    checkCsr(adr, expected, csrRData);
    @(negedge clk);
  endtask

  // a CSR number outside both PMP blocks must not hit
  task automatic runMiss(input csrAdrT adr);
    csrAdr = adr;
    #20;
    if (csrHit) begin
      abortRun($sformatf("csrHit went high for CSR %h outside the PMP range", adr));
    end
    @(negedge clk);
  endtask

  task automatic runAccess(input accessReqT r, input accessRespT expected);
    int waitCnt;
    req      = r;
    reqValid = 1'b1;
    @(negedge clk);
    reqValid = 1'b0;
    waitCnt  = 0;
    while (!respValid && waitCnt < 10) begin
      @(negedge clk);
      waitCnt++;
    end
    if (!respValid) begin
      abortRun("no response came within 10 cycles of the access request");
    end
    checkResp(r, expected, resp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  function automatic csrAdrT cfgCsr(input int i);
    return csrPmpCfgBase + csrAdrT'(i);
  endfunction

  function automatic csrAdrT adrCsr(input int i);
    return csrPmpAdrBase + csrAdrT'(i);
  endfunction

  task automatic addWrite(input csrAdrT adr, input logic [xlen-1:0] data);
    stepT s;
    s      = '0;
    s.kind = stepWrite;
    s.adr  = adr;
    s.data = data;
    steps.push_back(s);
  endtask

  task automatic addRead(input csrAdrT adr, input logic [xlen-1:0] expected);
    stepT s;
    s      = '0;
    s.kind = stepRead;
    s.adr  = adr;
    s.data = expected;
    steps.push_back(s);
  endtask

  task automatic addMiss(input csrAdrT adr);
    stepT s;
    s      = '0;
    s.kind = stepMiss;
    s.adr  = adr;
    steps.push_back(s);
  endtask

  task automatic addAccess(input logic [paMax-1:0] adr, input accTypeT t, input privT p,
                           input logic fault, input logic matched, input logic [3:0] idx);
    stepT s;
    s                  = '0;
    s.kind             = stepAccess;
    s.req.adr          = adr;
    s.req.accType      = t;
    s.req.priv         = p;
    s.expResp.fault    = fault;
    s.expResp.matched  = matched;
    s.expResp.matchIdx = idx;
    steps.push_back(s);
  endtask

  task automatic buildTable();
    // every PMP CSR is zero out of reset
    for (int i = 0; i < 4; i++) begin
      addRead(cfgCsr(i), 32'h0);
    end
    for (int i = 0; i < 16; i++) begin
      addRead(adrCsr(i), 32'h0);
    end
    // mstatus and the number just below pmpcfg0 are not PMP CSRs
    addMiss(12'h300);
    addMiss(12'h39F);
    // reserved cfg bits are dropped, modes stay off for entries 12 to 15
    addWrite(adrCsr(15), 32'h1234_5678);
    addRead(adrCsr(15), 32'h1234_5678);
    addWrite(cfgCsr(3), 32'h6767_6767);
    addRead(cfgCsr(3), 32'h0707_0707);
    // TOR, entry 0 covers 0 to 0xfff with R, entry 1 covers 0x1000 to 0x1fff with RW
    addWrite(adrCsr(0), 32'h0000_0400);
    addWrite(adrCsr(1), 32'h0000_0800);
    addWrite(cfgCsr(0), 32'h0000_0B09);
    addAccess(34'h0_0000_0000, accRead, privUser, 1'b0, 1'b1, 4'd0);
    addAccess(34'h0_0000_0FFC, accRead, privUser, 1'b0, 1'b1, 4'd0);
    addAccess(34'h0_0000_0FFC, accWrite, privUser, 1'b1, 1'b1, 4'd0);
    addAccess(34'h0_0000_1000, accWrite, privUser, 1'b0, 1'b1, 4'd1);
    addAccess(34'h0_0000_1FFF, accRead, privUser, 1'b0, 1'b1, 4'd1);
    addAccess(34'h0_0000_2000, accRead, privUser, 1'b1, 1'b0, 4'd0);
    addAccess(34'h0_0000_2000, accRead, privMachine, 1'b0, 1'b0, 4'd0);
    // NA4 at 0x3000 with X, 8-byte NAPOT at 0x4000 with RW
    addWrite(adrCsr(2), 32'h0000_0C00);
    addWrite(adrCsr(3), 32'h0000_1000);
    addWrite(cfgCsr(0), 32'h1B14_0B09);
    addRead(cfgCsr(0), 32'h1B14_0B09);
    addAccess(34'h0_0000_3000, accExec, privUser, 1'b0, 1'b1, 4'd2);
    addAccess(34'h0_0000_3003, accExec, privUser, 1'b0, 1'b1, 4'd2);
    addAccess(34'h0_0000_3004, accExec, privUser, 1'b1, 1'b0, 4'd0);
    addAccess(34'h0_0000_2FFC, accExec, privUser, 1'b1, 1'b0, 4'd0);
    addAccess(34'h0_0000_3000, accRead, privUser, 1'b1, 1'b1, 4'd2);
    addAccess(34'h0_0000_4000, accWrite, privUser, 1'b0, 1'b1, 4'd3);
    addAccess(34'h0_0000_4007, accRead, privUser, 1'b0, 1'b1, 4'd3);
    addAccess(34'h0_0000_4008, accRead, privUser, 1'b1, 1'b0, 4'd0);
    // 64 KiB NAPOT for entry 4 with R only
    addWrite(adrCsr(4), 32'hAAF3_5FFF);
    addWrite(cfgCsr(1), 32'h0000_0019);
    addAccess(napotBase, accRead, privUser, 1'b0, 1'b1, 4'd4);
    addAccess(34'h2_ABCD_FFFF, accRead, privUser, 1'b0, 1'b1, 4'd4);
    addAccess(34'h2_ABCE_0000, accRead, privUser, 1'b1, 1'b0, 4'd0);
    addAccess(34'h2_ABCC_FFFC, accRead, privUser, 1'b1, 1'b0, 4'd0);
    // entry 5 (RW) sits inside entry 4, entry 6 (X, 4 KiB at 0x4000) under entry 3
    addWrite(adrCsr(5), 32'hAAF3_45FF);
    addWrite(adrCsr(6), 32'h0000_11FF);
    addWrite(cfgCsr(1), 32'h001C_1B19);
    addAccess(34'h2_ABCD_1000, accWrite, privUser, 1'b1, 1'b1, 4'd4);
    addAccess(34'h0_0000_4000, accExec, privUser, 1'b1, 1'b1, 4'd3);
    addAccess(34'h0_0000_4010, accExec, privUser, 1'b0, 1'b1, 4'd6);
    addAccess(34'h0_0000_4008, accWrite, privUser, 1'b1, 1'b1, 4'd6);
    // machine mode ignores unlocked permissions, supervisor misses fault
    addAccess(34'h0_0000_3000, accWrite, privMachine, 1'b0, 1'b1, 4'd2);
    addAccess(34'h0_0000_5000, accRead, privSuper, 1'b1, 1'b0, 4'd0);
    addAccess(34'h0_0000_5000, accExec, privMachine, 1'b0, 1'b0, 4'd0);
    // entry 9 is a locked TOR from 0x8000 to 0x8fff with R only
    addWrite(adrCsr(8), 32'h0000_2000);
    addWrite(adrCsr(9), 32'h0000_2400);
    addWrite(cfgCsr(2), 32'h0000_8900);
    addRead(cfgCsr(2), 32'h0000_8900);
    addAccess(34'h0_0000_8000, accRead, privMachine, 1'b0, 1'b1, 4'd9);
    addAccess(34'h0_0000_8FFC, accWrite, privMachine, 1'b1, 1'b1, 4'd9);
    addAccess(34'h0_0000_7FFC, accRead, privMachine, 1'b0, 1'b0, 4'd0);
    // the locked byte and both bounds of the locked TOR entry stay put
    addWrite(cfgCsr(2), 32'h0000_0F01);
    addRead(cfgCsr(2), 32'h0000_8901);
    addWrite(adrCsr(9), 32'h0000_3000);
    addRead(adrCsr(9), 32'h0000_2400);
    addWrite(adrCsr(8), 32'h0000_1000);
    addRead(adrCsr(8), 32'h0000_2000);
    addWrite(adrCsr(7), 32'h0000_0055);
    addRead(adrCsr(7), 32'h0000_0055);
    addAccess(34'h0_0000_8FFC, accRead, privUser, 1'b0, 1'b1, 4'd9);
  endtask

  // random draws around entry 4, inside when the bits above the region size equal the base
  task automatic sweepNapot();
    logic [31:0]      rnd;
    logic [paMax-1:0] adr;
    logic             inRegion;
    accessReqT        r;
    accessRespT       e;
    for (int n = 0; n < 200; n++) begin
      rnd = $random(seed);
      adr = {napotBase[paMax-1:20], rnd[19:0]};
      // about half of the draws are pulled into the region itself
      if (rnd[31]) begin
        adr[19:16] = napotBase[19:16];
      end
      inRegion   = (adr[paMax-1:16] == napotBase[paMax-1:16]);
      r.adr      = adr;
      r.accType  = rnd[30] ? accWrite : accRead;
      r.priv     = privUser;
      e.fault    = !inRegion || rnd[30];
      e.matched  = inRegion;
      e.matchIdx = inRegion ? 4'd4 : 4'd0;
      runAccess(r, e);
    end
  endtask

  initial begin
    clk      = 1'b0;
    arstN    = 1'b0;
    csrWrite = 1'b0;
    csrAdr   = '0;
    csrWData = '0;
    reqValid = 1'b0;
    req      = '0;
    seed     = 52239;
    buildTable();
    repeat (8) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    if (respValid) begin
      abortRun("respValid is high right after reset");
    end
    foreach (steps[i]) begin
      case (steps[i].kind)
        stepWrite: runWrite(steps[i].adr, steps[i].data);
        stepRead:  runRead(steps[i].adr, steps[i].data);
        stepMiss:  runMiss(steps[i].adr);
        default:   runAccess(steps[i].req, steps[i].expResp);
      endcase
    end
    sweepNapot();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
hdl/pmpPkg.sv
hdl/pmpAdrDec.sv
hdl/pmpCsrFile.sv
hdl/pmpPrioritySel.sv
hdl/pmpChecker.sv
hdl/pmpUnit.sv
testbench/pmpUnitTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# builds the PMP unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log
simBin=pmpUnitTbSim

verilator --binary --timing --top-module pmpUnitTb --Mdir "$buildDir" \
  -f sources.f -o "$simBin"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/$simBin" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "TEST FAIL" "$logFile"; then
  echo "simulation reported a failure"
  exit 1
fi

if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

echo "simulation finished without failures"
exit 0
